//--- Bender.yml
package:
  name: id_stage

sources:
  - design/id_pkg.sv
  - design/id_decoder.sv
  - design/id_gpr_file.sv
  - design/id_operand_bypass.sv
  - design/id_branch_unit.sv
  - design/id_stage.sv
  - target: test
    files:
      - dv/id_stage_asserts.sv
      - dv/tb_id_stage.sv

//--- design/id_branch_unit.sv
// branch condition and jump target evaluation, resolved in decode
`timescale 1ns/1ps

module id_branch_unit (
  input  logic                    i_valid,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_rs1_data,
  input  logic [id_pkg::XLEN-1:0] i_rs2_data,
  input  logic [id_pkg::XLEN-1:0] i_imm,
  input  logic                    i_br_en,
  input  logic [2:0]              i_br_func,
  input  logic                    i_jal,
  input  logic                    i_jalr,
  output logic                    o_br_taken,
  output logic [id_pkg::XLEN-1:0] o_br_target
);

  logic                    cond;
  logic [id_pkg::XLEN-1:0] jalr_sum;

  always_comb begin
    case (i_br_func)
      3'b000:  cond = (i_rs1_data == i_rs2_data);                 // beq
      3'b001:  cond = (i_rs1_data != i_rs2_data);                 // bne
      3'b100:  cond = ($signed(i_rs1_data) <  $signed(i_rs2_data)); // blt
      3'b101:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data)); // bge
      3'b110:  cond = (i_rs1_data <  i_rs2_data);                 // bltu
      3'b111:  cond = (i_rs1_data >= i_rs2_data);                 // bgeu
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum    = i_rs1_data + i_imm;
  assign o_br_taken  = i_valid && (i_jal || i_jalr || (i_br_en && cond));
  assign o_br_target = i_jalr ? {jalr_sum[id_pkg::XLEN-1:1], 1'b0} : i_pc + i_imm;

endmodule

//--- design/id_decoder.sv
// combinational RV64I subset decoder, turns the held instruction into operand and control fields
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::inst_u                   i_inst,
  output logic [id_pkg::REG_ADDR_W-1:0]   o_rs1,
  output logic [id_pkg::REG_ADDR_W-1:0]   o_rs2,
  output logic [id_pkg::REG_ADDR_W-1:0]   o_rd,
  output logic [id_pkg::XLEN-1:0]         o_imm,
  output logic [id_pkg::ALU_OP_W-1:0]     o_alu_op,
  output logic                            o_alu_src1_pc,
  output logic                            o_alu_src2_imm,
  output logic                            o_gpr_wen,
  output logic                            o_mem_ren,
  output logic                            o_mem_wen,
  output logic [id_pkg::MEM_OP_W-1:0]     o_mem_op,
  output logic                            o_load_sel,
  output logic                            o_br_en,
  output logic [2:0]                      o_br_func,
  output logic                            o_jal,
  output logic                            o_jalr,
  output logic                            o_invalid_inst
);

  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_s;
  logic [id_pkg::XLEN-1:0] imm_b;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_j;
  logic                    sra_sel; // bit 30 selects sub/sra

  function automatic logic [id_pkg::ALU_OP_W-1:0] alu_decode(input logic [2:0] funct3,
                                                             input logic       alt);
    logic [id_pkg::ALU_OP_W-1:0] op;
    case (funct3)
      3'b000:  op = alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
      3'b001:  op = id_pkg::ALU_SLL;
      3'b010:  op = id_pkg::ALU_SLT;
      3'b011:  op = id_pkg::ALU_SLTU;
      3'b100:  op = id_pkg::ALU_XOR;
      3'b101:  op = alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  op = id_pkg::ALU_OR;
      default: op = id_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign imm_i = {{(id_pkg::XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_s = {{(id_pkg::XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
  assign imm_b = {{(id_pkg::XLEN-12){i_inst.b.imm12}}, i_inst.b.imm11,
                  i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
  assign imm_u = {{(id_pkg::XLEN-32){i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
  assign imm_j = {{(id_pkg::XLEN-20){i_inst.j.imm20}}, i_inst.j.imm19_12,
                  i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};

  assign sra_sel   = i_inst.r.funct7[5];
  assign o_mem_op  = i_inst.s.funct3;
  assign o_br_func = i_inst.b.funct3;

  always_comb begin
    o_rs1          = '0; // unused indices stay x0, no false hazards
    o_rs2          = '0;
    o_rd           = '0;
    o_imm          = '0;
    o_alu_op       = id_pkg::ALU_ADD;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2_imm = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_load_sel     = 1'b0;
    o_br_en        = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_invalid_inst = 1'b0;
    case (i_inst.r.opcode)
      id_pkg::OPC_OP: begin
        o_rs1     = i_inst.r.rs1;
        o_rs2     = i_inst.r.rs2;
        o_rd      = i_inst.r.rd;
        o_alu_op  = alu_decode(i_inst.r.funct3, sra_sel);
        o_gpr_wen = 1'b1;
      end
      id_pkg::OPC_OP_IMM: begin
        o_rs1          = i_inst.i.rs1;
        o_rd           = i_inst.i.rd;
        o_imm          = imm_i;
        o_alu_op       = alu_decode(i_inst.i.funct3, (i_inst.i.funct3 == 3'b101) && sra_sel);
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
      end
      id_pkg::OPC_LUI: begin
        o_rd           = i_inst.u.rd;
        o_imm          = imm_u;
        o_alu_op       = id_pkg::ALU_LUI;
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
      end
      id_pkg::OPC_AUIPC: begin
        o_rd           = i_inst.u.rd;
        o_imm          = imm_u;
        o_alu_src1_pc  = 1'b1;
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
      end
      id_pkg::OPC_JAL: begin
        o_rd          = i_inst.j.rd;
        o_imm         = imm_j;
        o_alu_src1_pc = 1'b1; // link is pc + 4, formed in execute
        o_gpr_wen     = 1'b1;
        o_jal         = 1'b1;
      end
      id_pkg::OPC_JALR: begin
        o_rs1         = i_inst.i.rs1;
        o_rd          = i_inst.i.rd;
        o_imm         = imm_i;
        o_alu_src1_pc = 1'b1;
        o_gpr_wen     = 1'b1;
        o_jalr        = 1'b1;
      end
      id_pkg::OPC_BRANCH: begin
        o_rs1   = i_inst.b.rs1;
        o_rs2   = i_inst.b.rs2;
        o_imm   = imm_b;
        o_br_en = 1'b1;
      end
      id_pkg::OPC_LOAD: begin
        o_rs1          = i_inst.i.rs1;
        o_rd           = i_inst.i.rd;
        o_imm          = imm_i;
        o_alu_src2_imm = 1'b1; // address = rs1 + imm
        o_gpr_wen      = 1'b1;
        o_mem_ren      = 1'b1;
        o_load_sel     = 1'b1;
      end
      id_pkg::OPC_STORE: begin
        o_rs1          = i_inst.s.rs1;
        o_rs2          = i_inst.s.rs2;
        o_imm          = imm_s;
        o_alu_src2_imm = 1'b1;
        o_mem_wen      = 1'b1;
      end
      default: o_invalid_inst = 1'b1;
    endcase
  end

endmodule

//--- design/id_gpr_file.sv
// 32 x 64-bit general purpose registers, two async read ports and one clocked write port
`timescale 1ns/1ps

module id_gpr_file (
  input  logic                           i_clk,
  input  logic                           i_reset,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_raddr1,
  output logic [id_pkg::XLEN-1:0]        o_rdata1,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_raddr2,
  output logic [id_pkg::XLEN-1:0]        o_rdata2,
  input  logic                           i_wen,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_waddr,
  input  logic [id_pkg::XLEN-1:0]        i_wdata
);

  logic [id_pkg::XLEN-1:0] regs [2**id_pkg::REG_ADDR_W];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < 2**id_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin // x0 never written
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- design/id_operand_bypass.sv
// operand forwarding from execute, memory and writeback with load-use and memory-hit flags
`timescale 1ns/1ps

module id_operand_bypass (
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_rs1,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_rs2,
  input  logic [id_pkg::XLEN-1:0]        i_rf_rdata1,
  input  logic [id_pkg::XLEN-1:0]        i_rf_rdata2,
  input  logic                           i_es_load,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_es_rd,
  input  logic [id_pkg::XLEN-1:0]        i_es_result,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_ms_rd,
  input  logic [id_pkg::XLEN-1:0]        i_ms_result,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_ws_rd,
  input  logic [id_pkg::XLEN-1:0]        i_ws_result,
  output logic [id_pkg::XLEN-1:0]        o_rs1_data,
  output logic [id_pkg::XLEN-1:0]        o_rs2_data,
  output logic                           o_load_use_hit,
  output logic                           o_ms_hit
);

  logic es_m1, es_m2;
  logic ms_m1, ms_m2;
  logic ws_m1, ws_m2;

  // rd of zero means nothing to forward
  assign es_m1 = (i_es_rd != '0) && (i_es_rd == i_rs1);
  assign es_m2 = (i_es_rd != '0) && (i_es_rd == i_rs2);
  assign ms_m1 = (i_ms_rd != '0) && (i_ms_rd == i_rs1);
  assign ms_m2 = (i_ms_rd != '0) && (i_ms_rd == i_rs2);
  assign ws_m1 = (i_ws_rd != '0) && (i_ws_rd == i_rs1);
  assign ws_m2 = (i_ws_rd != '0) && (i_ws_rd == i_rs2);

  // youngest producer wins
  assign o_rs1_data = es_m1 ? i_es_result :
                      ms_m1 ? i_ms_result :
                      ws_m1 ? i_ws_result : i_rf_rdata1;
  assign o_rs2_data = es_m2 ? i_es_result :
                      ms_m2 ? i_ms_result :
                      ws_m2 ? i_ws_result : i_rf_rdata2;

  assign o_load_use_hit = i_es_load && (es_m1 || es_m2);
  assign o_ms_hit       = (ms_m1 && !es_m1) || (ms_m2 && !es_m2); // operand really taken from mem

endmodule

//--- design/id_pkg.sv
// shared widths, opcodes, operation codes and instruction views for the decode stage
package id_pkg;

  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int ALU_OP_W   = 4;
  localparam int MEM_OP_W   = 3; // funct3 of load/store

  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd10; // passes operand 2

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // addi x0, x0, 0
  localparam logic [INST_W-1:0] NOP_INST = 32'h00000013;

  // one instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_u;

endpackage

//--- design/id_stage.sv
// decode stage top, pipe register with valid/allowin handshake, hazard stalls and branch squash
`timescale 1ns/1ps

module id_stage (
  input  logic                           i_clk,
  input  logic                           i_reset,
  // fetch side
  input  logic                           i_fs_valid,
  input  logic [id_pkg::INST_W-1:0]      i_fs_inst,
  input  logic [id_pkg::XLEN-1:0]        i_fs_pc,
  output logic                           o_ds_allowin,
  // execute side
  input  logic                           i_es_allowin,
  output logic                           o_ds_to_es_valid,
  output logic [id_pkg::XLEN-1:0]        o_pc,
  output logic [id_pkg::XLEN-1:0]        o_rs1_data,
  output logic [id_pkg::XLEN-1:0]        o_rs2_data,
  output logic [id_pkg::XLEN-1:0]        o_imm,
  output logic [id_pkg::REG_ADDR_W-1:0]  o_rd,
  output logic [id_pkg::ALU_OP_W-1:0]    o_alu_op,
  output logic                           o_alu_src1_pc,
  output logic                           o_alu_src2_imm,
  output logic                           o_gpr_wen,
  output logic                           o_mem_ren,
  output logic                           o_mem_wen,
  output logic [id_pkg::MEM_OP_W-1:0]    o_mem_op,
  output logic                           o_load_sel,
  output logic                           o_invalid_inst,
  // branch to fetch
  output logic                           o_br_taken,
  output logic                           o_br_stall,
  output logic [id_pkg::XLEN-1:0]        o_br_target,
  // forwarding
  input  logic                           i_es_load,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_es_rd,
  input  logic [id_pkg::XLEN-1:0]        i_es_result,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_ms_rd,
  input  logic [id_pkg::XLEN-1:0]        i_ms_result,
  input  logic                           i_ms_data_stall,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_ws_rd,
  input  logic [id_pkg::XLEN-1:0]        i_ws_result,
  // writeback port
  input  logic                           i_rf_wen,
  input  logic [id_pkg::REG_ADDR_W-1:0]  i_rf_waddr,
  input  logic [id_pkg::XLEN-1:0]        i_rf_wdata
);

  logic                          ds_valid;
  logic                          ds_ready_go;
  id_pkg::inst_u                 ds_inst;
  logic [id_pkg::XLEN-1:0]       ds_pc;
  logic [id_pkg::REG_ADDR_W-1:0] rs1, rs2;
  logic [id_pkg::XLEN-1:0]       rf_rdata1, rf_rdata2;
  logic                          load_use_hit;
  logic                          ms_hit;
  logic                          br_en;
  logic [2:0]                    br_func;
  logic                          jal, jalr;

  // wait for a load in execute or a memory result that is not back yet
  assign ds_ready_go      = !load_use_hit && !(i_ms_data_stall && ms_hit);
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign o_br_stall       = o_br_taken && !ds_ready_go;
  assign o_pc             = ds_pc;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_inst <= o_br_taken ? id_pkg::NOP_INST : i_fs_inst; // squash the slot behind a taken branch
      ds_pc   <= i_fs_pc;
    end
  end

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_pc  (o_alu_src1_pc),
    .o_alu_src2_imm (o_alu_src2_imm),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_mem_op       (o_mem_op),
    .o_load_sel     (o_load_sel),
    .o_br_en        (br_en),
    .o_br_func      (br_func),
    .o_jal          (jal),
    .o_jalr         (jalr),
    .o_invalid_inst (o_invalid_inst)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_raddr1 (rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (rs2),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata)
  );

  id_operand_bypass u_bypass (
    .i_rs1          (rs1),
    .i_rs2          (rs2),
    .i_rf_rdata1    (rf_rdata1),
    .i_rf_rdata2    (rf_rdata2),
    .i_es_load      (i_es_load),
    .i_es_rd        (i_es_rd),
    .i_es_result    (i_es_result),
    .i_ms_rd        (i_ms_rd),
    .i_ms_result    (i_ms_result),
    .i_ws_rd        (i_ws_rd),
    .i_ws_result    (i_ws_result),
    .o_rs1_data     (o_rs1_data),
    .o_rs2_data     (o_rs2_data),
    .o_load_use_hit (load_use_hit),
    .o_ms_hit       (ms_hit)
  );

  id_branch_unit u_branch (
    .i_valid     (ds_valid),
    .i_pc        (ds_pc),
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_imm       (o_imm),
    .i_br_en     (br_en),
    .i_br_func   (br_func),
    .i_jal       (jal),
    .i_jalr      (jalr),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

//--- dv/id_stage_asserts.sv
// concurrent protocol checks for the decode stage, attached to every id_stage by bind
`timescale 1ns/1ps

module id_stage_asserts (
  input logic                           i_clk,
  input logic                           i_reset,
  input logic                           i_es_allowin,
  input logic                           o_ds_to_es_valid,
  input logic                           o_br_stall,
  input logic [id_pkg::XLEN-1:0]        o_pc,
  input logic [id_pkg::REG_ADDR_W-1:0]  o_rd
);

  int assert_errors = 0;

  no_valid_in_reset: assert property (@(posedge i_clk) i_reset |=> !o_ds_to_es_valid)
    else begin
      $error("decode output valid while reset is held");
      assert_errors++;
    end

  // a stalled taken branch keeps its slot
  stall_holds_branch: assert property (@(posedge i_clk) disable iff (i_reset)
                                       o_br_stall |=> (o_pc == $past(o_pc)))
    else begin
      $error("pc moved while the taken branch was stalled");
      assert_errors++;
    end

  // held instruction stays put under back-pressure
  hold_on_backpressure: assert property (@(posedge i_clk) disable iff (i_reset)
      (o_ds_to_es_valid && !i_es_allowin) |=> (o_pc == $past(o_pc)) && (o_rd == $past(o_rd)))
    else begin
      $error("pc or rd changed while execute refused the instruction");
      assert_errors++;
    end

endmodule

bind id_stage id_stage_asserts u_asserts (
  .i_clk            (i_clk),
  .i_reset          (i_reset),
  .i_es_allowin     (i_es_allowin),
  .o_ds_to_es_valid (o_ds_to_es_valid),
  .o_br_stall       (o_br_stall),
  .o_pc             (o_pc),
  .o_rd             (o_rd)
);

//--- dv/tb_id_stage.sv
// directed testbench for the decode stage, run as the simulation top with the bound assertions
`timescale 1ns/1ps

module tb_id_stage;

  localparam int MAX_CYCLES = 400; // six tests of about 40 cycles plus margin

  logic                           i_clk;
  logic                           i_reset;
  logic                           i_fs_valid;
  logic [id_pkg::INST_W-1:0]      i_fs_inst;
  logic [id_pkg::XLEN-1:0]        i_fs_pc;
  logic                           o_ds_allowin;
  logic                           i_es_allowin;
  logic                           o_ds_to_es_valid;
  logic [id_pkg::XLEN-1:0]        o_pc, o_rs1_data, o_rs2_data, o_imm;
  logic [id_pkg::REG_ADDR_W-1:0]  o_rd;
  logic [id_pkg::ALU_OP_W-1:0]    o_alu_op;
  logic                           o_alu_src1_pc, o_alu_src2_imm, o_gpr_wen;
  logic                           o_mem_ren, o_mem_wen, o_load_sel, o_invalid_inst;
  logic [id_pkg::MEM_OP_W-1:0]    o_mem_op;
  logic                           o_br_taken, o_br_stall;
  logic [id_pkg::XLEN-1:0]        o_br_target;
  logic                           i_es_load, i_ms_data_stall;
  logic [id_pkg::REG_ADDR_W-1:0]  i_es_rd, i_ms_rd, i_ws_rd;
  logic [id_pkg::XLEN-1:0]        i_es_result, i_ms_result, i_ws_result;
  logic                           i_rf_wen;
  logic [id_pkg::REG_ADDR_W-1:0]  i_rf_waddr;
  logic [id_pkg::XLEN-1:0]        i_rf_wdata;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int total;
  logic [id_pkg::XLEN-1:0] v5, v6, r1, r2, r3;

  id_stage dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles, a handshake never completed", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic check_data(input logic [id_pkg::XLEN-1:0] got,
                            input logic [id_pkg::XLEN-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_field(input logic [id_pkg::REG_ADDR_W-1:0] got,
                             input logic [id_pkg::REG_ADDR_W-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] add_word(input logic [4:0] rd, rs1, rs2);
    id_pkg::inst_u w;
    w          = '0;
    w.r.opcode = id_pkg::OPC_OP; // funct3 and funct7 zero for add
    w.r.rd     = rd;
    w.r.rs1    = rs1;
    w.r.rs2    = rs2;
    return w;
  endfunction

  function automatic logic [31:0] itype_word(input logic [6:0] opc, input logic [2:0] funct3,
                                             input logic [11:0] imm,
                                             input logic [4:0] rs1, input logic [4:0] rd);
    id_pkg::inst_u w;
    w          = '0;
    w.i.opcode = opc;
    w.i.funct3 = funct3;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.rd     = rd;
    return w;
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] funct3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    id_pkg::inst_u w;
    w           = '0;
    w.b.opcode  = id_pkg::OPC_BRANCH;
    w.b.funct3  = funct3;
    w.b.rs1     = rs1;
    w.b.rs2     = rs2;
    w.b.imm12   = off[12];
    w.b.imm11   = off[11];
    w.b.imm10_5 = off[10:5];
    w.b.imm4_1  = off[4:1];
    return w;
  endfunction

  task automatic step(); // inputs move 2 ns after the edge
    @(posedge i_clk);
    #2;
  endtask

  task automatic settle();
    @(negedge i_clk);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [id_pkg::XLEN-1:0] data);
    i_rf_wen   = 1'b1;
    i_rf_waddr = addr;
    i_rf_wdata = data;
    step();
    i_rf_wen   = 1'b0;
  endtask

  // present one instruction and hold it until decode takes it
  task automatic send_inst(input logic [31:0] inst, input logic [id_pkg::XLEN-1:0] pc);
    i_fs_valid = 1'b1;
    i_fs_inst  = inst;
    i_fs_pc    = pc;
    settle();
    while (!o_ds_allowin) settle();
    step();
    i_fs_valid = 1'b0;
  endtask

  task automatic release_stage();
    step();
    i_es_allowin = 1'b1;
    step();
    settle();
    check_bit(o_ds_to_es_valid, 1'b0, "valid after transfer");
    step();
  endtask

  task automatic reset_checks();
    settle();
    check_bit(o_ds_to_es_valid, 1'b0, "valid after reset");
    check_bit(o_br_taken, 1'b0, "br_taken after reset");
    check_bit(o_ds_allowin, 1'b1, "allowin after reset");
    step();
  endtask

  task automatic decode_and_read();
    write_reg(5'd5, v5);
    write_reg(5'd6, v6);
    send_inst(add_word(5'd7, 5'd5, 5'd6), 64'h80);
    settle();
    check_bit(o_ds_to_es_valid, 1'b1, "add valid");
    check_data(o_rs1_data, v5, "add rs1 data");
    check_data(o_rs2_data, v6, "add rs2 data");
    check_field(o_rd, 5'd7, "add rd");
    check_field({1'b0, o_alu_op}, {1'b0, id_pkg::ALU_ADD}, "add alu op");
    check_bit(o_gpr_wen, 1'b1, "add gpr_wen");
    check_bit(o_alu_src1_pc, 1'b0, "add src1 pc");
    check_bit(o_invalid_inst, 1'b0, "add invalid");
    check_data(o_pc, 64'h80, "add pc");
    release_stage();
    send_inst(itype_word(id_pkg::OPC_OP_IMM, 3'b000, 12'hffd, 5'd5, 5'd7), 64'h84);
    settle();
    check_data(o_rs1_data, v5, "addi rs1 data");
    check_data(o_imm, 64'hffff_ffff_ffff_fffd, "addi imm"); // -3 sign extended
    check_field({1'b0, o_alu_op}, {1'b0, id_pkg::ALU_ADD}, "addi alu op");
    check_field(o_rd, 5'd7, "addi rd");
    check_bit(o_alu_src2_imm, 1'b1, "addi src2 imm");
    check_bit(o_gpr_wen, 1'b1, "addi gpr_wen");
    release_stage();
    send_inst(itype_word(id_pkg::OPC_LOAD, 3'b011, 12'd8, 5'd5, 5'd10), 64'h88);
    settle();
    check_field(o_rd, 5'd10, "ld rd");
    check_data(o_imm, 64'd8, "ld imm");
    check_bit(o_mem_ren, 1'b1, "ld mem_ren");
    check_bit(o_load_sel, 1'b1, "ld load_sel");
    check_bit(o_mem_wen, 1'b0, "ld mem_wen");
    check_field({2'b00, o_mem_op}, 5'd3, "ld mem op");
    check_bit(o_gpr_wen, 1'b1, "ld gpr_wen");
    release_stage();
    send_inst(32'h0062b823, 64'h8c); // sd x6, 16(x5)
    settle();
    check_data(o_rs2_data, v6, "sd rs2 data");
    check_data(o_imm, 64'd16, "sd imm");
    check_bit(o_mem_wen, 1'b1, "sd mem_wen");
    check_bit(o_mem_ren, 1'b0, "sd mem_ren");
    check_bit(o_load_sel, 1'b0, "sd load_sel");
    check_bit(o_gpr_wen, 1'b0, "sd gpr_wen");
    check_field({2'b00, o_mem_op}, 5'd3, "sd mem op");
    release_stage();
    send_inst(32'hffff_ffff, 64'h90); // opcode 7'h7f not in the subset
    settle();
    check_bit(o_invalid_inst, 1'b1, "unknown opcode flagged");
    check_bit(o_gpr_wen, 1'b0, "unknown gpr_wen");
    check_bit(o_mem_ren, 1'b0, "unknown mem_ren");
    check_bit(o_mem_wen, 1'b0, "unknown mem_wen");
    release_stage();
  endtask

  task automatic forward_priority();
    i_es_allowin = 1'b0; // park the instruction
    send_inst(add_word(5'd8, 5'd5, 5'd6), 64'h100);
    step();
    i_es_rd     = 5'd5;
    i_es_result = r1;
    i_ms_rd     = 5'd5;
    i_ms_result = r2;
    settle();
    check_data(o_rs1_data, r1, "rs1 with es and ms match");
    step();
    i_es_rd     = '0;
    i_ms_rd     = '0;
    i_ws_rd     = 5'd5;
    i_ws_result = r3;
    settle();
    check_data(o_rs1_data, r3, "rs1 with ws match");
    check_data(o_rs2_data, v6, "rs2 without match");
    step();
    i_ws_rd = '0;
    settle();
    check_data(o_rs1_data, v5, "rs1 from register file");
    release_stage();
  endtask

  task automatic hazard_stalls();
    i_es_load   = 1'b1;
    i_es_rd     = 5'd6;
    i_es_result = r1;
    send_inst(add_word(5'd9, 5'd5, 5'd6), 64'h200);
    repeat (2) begin
      settle();
      check_bit(o_ds_to_es_valid, 1'b0, "valid during load-use");
      check_bit(o_ds_allowin, 1'b0, "allowin during load-use");
      step();
    end
    i_es_load = 1'b0;
    settle();
    check_bit(o_ds_to_es_valid, 1'b1, "valid after load-use");
    check_data(o_rs2_data, r1, "rs2 after load-use");
    release_stage();
    i_es_rd         = '0;
    i_ms_rd         = 5'd5;
    i_ms_result     = r2;
    i_ms_data_stall = 1'b1;
    send_inst(add_word(5'd9, 5'd5, 5'd6), 64'h204);
    settle();
    check_bit(o_ds_to_es_valid, 1'b0, "valid during mem stall");
    check_bit(o_ds_allowin, 1'b0, "allowin during mem stall");
    step();
    i_ms_data_stall = 1'b0;
    settle();
    check_bit(o_ds_to_es_valid, 1'b1, "valid after mem stall");
    check_data(o_rs1_data, r2, "rs1 after mem stall");
    release_stage();
    i_ms_rd = '0;
  endtask

  task automatic branch_and_squash();
    logic [id_pkg::XLEN-1:0] jalr_exp;
    send_inst(branch_word(3'b000, 5'd5, 5'd5, 13'd16), 64'h1000);
    i_fs_valid = 1'b1; // fall-through slot
    i_fs_inst  = add_word(5'd7, 5'd5, 5'd6);
    i_fs_pc    = 64'h1004;
    settle();
    check_bit(o_br_taken, 1'b1, "beq taken");
    check_data(o_br_target, 64'h1010, "beq target");
    check_bit(o_br_stall, 1'b0, "beq stall");
    check_bit(o_ds_allowin, 1'b1, "allowin behind beq");
    step();
    i_fs_valid = 1'b0;
    settle();
    check_data(o_pc, 64'h1004, "squashed pc");
    check_field(o_rd, 5'd0, "squashed rd");
    check_data(o_imm, 64'd0, "squashed imm");
    check_field({1'b0, o_alu_op}, {1'b0, id_pkg::ALU_ADD}, "squashed alu op");
    check_bit(o_br_taken, 1'b0, "squashed br_taken");
    release_stage();
    send_inst(branch_word(3'b001, 5'd5, 5'd5, 13'd16), 64'h1100);
    settle();
    check_bit(o_br_taken, 1'b0, "bne equal operands");
    release_stage();
    jalr_exp = (v5 + 64'd7) & ~64'd1;
    send_inst(itype_word(id_pkg::OPC_JALR, 3'b000, 12'd7, 5'd5, 5'd1), 64'h1200);
    settle();
    check_bit(o_br_taken, 1'b1, "jalr taken");
    check_data(o_br_target, jalr_exp, "jalr target");
    check_bit(o_alu_src1_pc, 1'b1, "jalr src1 pc");
    release_stage();
    i_es_load   = 1'b1;
    i_es_rd     = 5'd5;
    i_es_result = r1;
    send_inst(branch_word(3'b000, 5'd5, 5'd5, 13'd16), 64'h1300);
    i_fs_valid = 1'b1; // fall-through waits behind the stalled branch
    i_fs_inst  = add_word(5'd7, 5'd5, 5'd6);
    i_fs_pc    = 64'h1304;
    settle();
    check_bit(o_br_taken, 1'b1, "beq taken under load-use");
    check_bit(o_br_stall, 1'b1, "br_stall under load-use");
    check_bit(o_ds_allowin, 1'b0, "allowin under br_stall");
    step();
    i_es_load = 1'b0;
    settle();
    check_bit(o_br_stall, 1'b0, "br_stall after load-use");
    check_bit(o_ds_to_es_valid, 1'b1, "beq valid after load-use");
    check_data(o_pc, 64'h1300, "beq pc after load-use");
    step();
    i_fs_valid = 1'b0;
    settle();
    check_data(o_pc, 64'h1304, "squashed pc after stall");
    check_field(o_rd, 5'd0, "squashed rd after stall");
    release_stage();
    i_es_rd = '0;
  endtask

  task automatic back_pressure();
    i_es_allowin = 1'b0;
    send_inst(add_word(5'd7, 5'd5, 5'd6), 64'h2000);
    i_fs_valid = 1'b1;
    i_fs_inst  = itype_word(id_pkg::OPC_OP_IMM, 3'b000, 12'hffd, 5'd5, 5'd8);
    i_fs_pc    = 64'h2004;
    repeat (3) begin
      settle();
      check_bit(o_ds_allowin, 1'b0, "allowin under back-pressure");
      check_bit(o_ds_to_es_valid, 1'b1, "valid under back-pressure");
      check_data(o_pc, 64'h2000, "held pc");
      check_field(o_rd, 5'd7, "held rd");
      check_data(o_rs1_data, v5, "held rs1 data");
      step();
    end
    i_es_allowin = 1'b1;
    settle();
    check_bit(o_ds_allowin, 1'b1, "allowin after release");
    step();
    i_fs_valid = 1'b0;
    settle();
    check_data(o_pc, 64'h2004, "next pc");
    check_field(o_rd, 5'd8, "next rd");
    release_stage();
  endtask

  initial begin
    void'($urandom(32'h40f78438));
    i_reset         = 1'b1;
    i_fs_valid      = 1'b0;
    i_fs_inst       = id_pkg::NOP_INST;
    i_fs_pc         = '0;
    i_es_allowin    = 1'b1;
    i_es_load       = 1'b0;
    i_es_rd         = '0;
    i_es_result     = '0;
    i_ms_rd         = '0;
    i_ms_result     = '0;
    i_ms_data_stall = 1'b0;
    i_ws_rd         = '0;
    i_ws_result     = '0;
    i_rf_wen        = 1'b0;
    i_rf_waddr      = '0;
    i_rf_wdata      = '0;
    v5 = {$urandom, $urandom};
    v6 = {$urandom, $urandom};
    r1 = {$urandom, $urandom};
    r2 = {$urandom, $urandom};
    r3 = {$urandom, $urandom};
    repeat (5) @(posedge i_clk);
    #2;
    i_reset = 1'b0;
    reset_checks();
    decode_and_read();
    forward_priority();
    hazard_stalls();
    branch_and_squash();
    back_pressure();
    total = errors + dut.u_asserts.assert_errors;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             dut.u_asserts.assert_errors);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
design/id_pkg.sv
design/id_decoder.sv
design/id_gpr_file.sv
design/id_operand_bypass.sv
design/id_branch_unit.sv
design/id_stage.sv
dv/id_stage_asserts.sv
dv/tb_id_stage.sv
